// ==== flist.f ====
+incdir+.
rename_types_pkg.sv
dispatch_pkg.sv
rat.sv
rename.sv
rename_unit_top.sv
tb_rename_unit.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= tb_rename_unit
FLIST      ?= flist.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
FAIL_MSG   ?= Done: errors found
PASS_MSG   ?= Done: no errors
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS  ?= --binary --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) -Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation FAILED, no result line"; exit 1)
	@echo "simulation PASSED"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb_rename_unit.sv ====
// operands are checked one cycle after acceptance; the shadow RAT has no checkpoint recovery
`timescale 1ns/1ps
`include "rename_config.svh"

module tb_rename_unit import rename_types_pkg::*, dispatch_pkg::*; ();

  localparam int RESET_CYCLES = 10;
  localparam int MAX_ROWS = 24;
  // flag order is rs1, rs2, imm, memory, pc, csr
  localparam logic [5:0] F_LUI   = 6'b001000;
  localparam logic [5:0] F_AUIPC = 6'b001010;
  localparam logic [5:0] F_ALUI  = 6'b101000;
  localparam logic [5:0] F_ALUR  = 6'b110000;
  localparam logic [5:0] F_LOAD  = 6'b101100;
  localparam logic [5:0] F_STORE = 6'b111100;
  localparam logic [5:0] F_CSR   = 6'b101001;
  localparam logic [`RD_W-1:0] NO_RD = 6'h20;

  typedef struct packed {
    logic                   valid;
    logic [`XLEN-1:2]       addr;
    robid_t                 id;
    logic [`RD_W-1:0]       rd;
    logic [`ARCH_REG_W-1:0] rs1;
    logic [`ARCH_REG_W-1:0] rs2;
    logic [`XLEN-1:0]       imm;
    logic [5:0]             flags;
    logic                   wb_v;
    robid_t                 wb_id;
    logic [`XLEN-1:0]       wb_val;
    logic                   ex_st;
    logic                   ls_st;
    logic                   flush;
    logic                   exp_stall;
    dispatch_target_e       exp_tgt;
    logic                   exp_r1;
    tag_or_value_u          exp_op1;
    logic                   exp_r2;
    tag_or_value_u          exp_op2;
  } row_t;

  logic clk = 1'b0;
  logic rst_n;
  logic decode_valid;
  logic [`XLEN-1:2] decode_addr;
  logic [`OP_W-1:0] decode_rsop;
  robid_t decode_robid;
  logic [`RD_W-1:0] decode_rd;
  logic [`ARCH_REG_W-1:0] decode_rs1;
  logic [`ARCH_REG_W-1:0] decode_rs2;
  logic [`XLEN-1:0] decode_imm;
  logic decode_uses_rs1, decode_uses_rs2, decode_uses_imm;
  logic decode_uses_memory, decode_uses_pc, decode_csr_access;
  logic stall;
  logic wb_valid;
  robid_t wb_robid;
  logic [`XLEN-1:0] wb_value;
  logic exers_stall, lsq_stall, flush;
  logic exers_write, lsq_write, csr_write;
  logic [`OP_W-1:0] op;
  robid_t robid;
  logic [`RD_W-1:0] rd;
  logic op1ready, op2ready;
  logic [`XLEN-1:0] op1;
  logic [`XLEN-1:0] op2;
  logic [`XLEN-1:0] imm;

  row_t rows [MAX_ROWS];
  int n_rows = 0;
  int cur_row = 0;
  int errors = 0;
  int checks = 0;
  int cycles = 0;
  int limit = 0;
  robid_t next_id = 8'h10;
  robid_t prev_id = '0;
  logic [`XLEN-1:0] rng_state;
  logic sh_ready [`RAT_DEPTH];
  tag_or_value_u sh_word [`RAT_DEPTH];

  rename_unit_top dut_i (.*);

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles > limit) begin
      $display("timeout: the table did not finish within %0d cycles", limit);
      $display("Done: errors found");
      $finish;
    end
  end

  function automatic logic [`XLEN-1:0] xorshift();
    logic [`XLEN-1:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic dispatch_target_e seen_target();
    if (exers_write) return TGT_EXERS;
    if (lsq_write) return TGT_LSQ;
    if (csr_write) return TGT_CSR;
    return TGT_NONE;
  endfunction

  task automatic add_instr(input logic [`RD_W-1:0] rd_f, input logic [`ARCH_REG_W-1:0] rs1_f,
                           input logic [`ARCH_REG_W-1:0] rs2_f, input logic [5:0] flags);
    row_t r;
    logic [`XLEN-1:0] rnd;
    r = '0;
    rnd = xorshift();
    r.valid = 1'b1;
    r.addr = rnd[`XLEN-1:2];
    r.imm = xorshift();
    r.id = next_id;
    r.rd = rd_f;
    r.rs1 = rs1_f;
    r.rs2 = rs2_f;
    r.flags = flags;
    rows[n_rows] = r;
    n_rows++;
    next_id = next_id + 1'b1;
  endtask

  // last row also carries the result of row k
  task automatic complete_row(input int k);
    rows[n_rows-1].wb_v = 1'b1;
    rows[n_rows-1].wb_id = rows[k].id;
    rows[n_rows-1].wb_val = xorshift();
  endtask

  task automatic hold_stalls(input logic ex, input logic ls);
    rows[n_rows-1].ex_st = ex;
    rows[n_rows-1].ls_st = ls;
  endtask

  // ALU instruction squashed by a flush in its decode cycle
  task automatic add_flush(input logic [`RD_W-1:0] rd_f, input logic [`ARCH_REG_W-1:0] rs1_f);
    add_instr(rd_f, rs1_f, 5'd0, F_ALUI);
    rows[n_rows-1].flush = 1'b1;
  endtask

  task automatic read_shadow(input logic [`ARCH_REG_W-1:0] idx, input row_t r,
                             output logic rdy, output tag_or_value_u word);
    rdy = sh_ready[idx];
    word = sh_word[idx];
    // writeback at the capture edge
    if (r.wb_v && !rdy && word.tag.robid == r.wb_id) begin
      rdy = 1'b1;
      word.value = r.wb_val;
    end
  endtask

  task automatic predict();
    row_t r;
    dispatch_target_e cls;
    logic rdy;
    tag_or_value_u w;
    for (int k = 0; k < `RAT_DEPTH; k++) begin
      sh_ready[k] = 1'b1;
      sh_word[k] = '0;
    end
    for (int i = 0; i < n_rows; i++) begin
      r = rows[i];
      if (r.flags[2]) cls = TGT_LSQ;
      else if (r.flags[0]) cls = TGT_CSR;
      else cls = TGT_EXERS;
      r.exp_stall = (cls == TGT_EXERS && r.ex_st) || (cls == TGT_LSQ && r.ls_st);
      r.exp_tgt = (r.valid && !r.flush) ? cls : TGT_NONE;
      r.exp_r1 = 1'b1;
      r.exp_r2 = 1'b1;
      r.exp_op1 = '0;
      r.exp_op2 = '0;
      if (!r.flags[5] && r.flags[1]) begin
        r.exp_op1.value = {r.addr, 2'b00};
        r.exp_op2.value = r.imm;
      end else if (!r.flags[5]) begin
        r.exp_op1.value = r.imm;
      end else begin
        read_shadow(r.rs1, r, rdy, w);
        r.exp_r1 = rdy;
        r.exp_op1 = w;
        if (r.flags[4]) begin
          read_shadow(r.rs2, r, rdy, w);
          r.exp_r2 = rdy;
          r.exp_op2 = w;
        end else begin
          r.exp_op2.value = r.imm;
        end
      end
      for (int k = 1; k < `RAT_DEPTH; k++) begin
        if (r.wb_v && !sh_ready[k] && sh_word[k].tag.robid == r.wb_id) begin
          sh_ready[k] = 1'b1;
          sh_word[k].value = r.wb_val;
        end
      end
      if (r.valid && !r.flush && !r.rd[`RD_W-1] && r.rd[`ARCH_REG_W-1:0] != '0) begin
        sh_ready[r.rd[`ARCH_REG_W-1:0]] = 1'b0;
        sh_word[r.rd[`ARCH_REG_W-1:0]].tag.zero = '0;
        sh_word[r.rd[`ARCH_REG_W-1:0]].tag.robid = r.id;
      end
      if (r.flush) begin
        for (int k = 0; k < `RAT_DEPTH; k++) sh_ready[k] = 1'b1;
      end
      rows[i] = r;
    end
  endtask

  task automatic drive_row(input row_t r);
    decode_valid <= r.valid;
    decode_addr  <= r.addr;
    decode_rsop  <= r.id[`OP_W-1:0];
    decode_robid <= r.id;
    decode_rd    <= r.rd;
    decode_rs1   <= r.rs1;
    decode_rs2   <= r.rs2;
    decode_imm   <= r.imm;
    {decode_uses_rs1, decode_uses_rs2, decode_uses_imm,
     decode_uses_memory, decode_uses_pc, decode_csr_access} <= r.flags;
    wb_valid    <= r.wb_v;
    wb_robid    <= r.wb_id;
    wb_value    <= r.wb_val;
    exers_stall <= r.ex_st;
    lsq_stall   <= r.ls_st;
    flush       <= r.flush;
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error %s: row %0d expected %h, got %h", name, cur_row, exp, got);
    end
  endtask

  task automatic check_robid(input string name, input robid_t got, input robid_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error %s: row %0d expected %h, got %h", name, cur_row, exp, got);
    end
  endtask

  task automatic check_op(input string name, input logic [`OP_W-1:0] got,
                          input logic [`OP_W-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error %s: row %0d expected %h, got %h", name, cur_row, exp, got);
    end
  endtask

  task automatic check_rd(input string name, input logic [`RD_W-1:0] got,
                          input logic [`RD_W-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error %s: row %0d expected %h, got %h", name, cur_row, exp, got);
    end
  endtask

  task automatic check_word(input string name, input logic [`XLEN-1:0] got,
                            input logic [`XLEN-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error %s: row %0d expected %h, got %h", name, cur_row, exp, got);
    end
  endtask

  task automatic check_target(input string name, input dispatch_target_e got,
                              input dispatch_target_e exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error %s: row %0d expected %h, got %h", name, cur_row, exp, got);
    end
  endtask

  task automatic check_operand(input string name, input logic got_rdy, input tag_or_value_u got,
                               input logic exp_rdy, input tag_or_value_u exp);
    checks++;
    if (got_rdy !== exp_rdy || got !== exp) begin
      errors++;
      if (exp_rdy)
        $display("error %s: row %0d expected ready value %h, got ready %h word %h",
                 name, cur_row, exp.value, got_rdy, got.value);
      else
        $display("error %s: row %0d expected pending tag %h, got ready %h word %h",
                 name, cur_row, exp.tag.robid, got_rdy, got.value);
    end
  endtask

  initial begin
    rng_state = 32'h50af;
    add_instr(6'd1, 5'd0, 5'd0, F_LUI);
    add_instr(6'd2, 5'd0, 5'd0, F_AUIPC);
    complete_row(0);
    add_instr(6'd3, 5'd1, 5'd0, F_ALUI);
    complete_row(1);
    add_instr(6'd4, 5'd2, 5'd1, F_ALUR);
    complete_row(2);
    add_instr(6'd5, 5'd3, 5'd0, F_LOAD);
    // x4 completes in the read cycle, x5 stays pending
    add_instr(NO_RD, 5'd4, 5'd5, F_STORE);
    complete_row(3);
    add_instr(6'd6, 5'd5, 5'd0, F_CSR);
    complete_row(4);
    add_instr(6'd7, 5'd5, 5'd4, F_ALUR);
    add_instr(6'd8, 5'd6, 5'd0, F_ALUI);
    hold_stalls(1'b1, 1'b0);
    add_instr(6'd9, 5'd7, 5'd0, F_LOAD);
    hold_stalls(1'b1, 1'b0);
    // squashed write to x3 must not reach the RAT
    add_flush(6'd3, 5'd1);
    add_instr(6'd10, 5'd8, 5'd9, F_ALUR);
    add_instr(6'd0, 5'd3, 5'd0, F_ALUI);
    add_instr(6'h21, 5'd2, 5'd0, F_ALUI);
    add_instr(6'd11, 5'd0, 5'd1, F_ALUR);
    add_instr(6'd12, 5'd11, 5'd0, F_LOAD);
    hold_stalls(1'b0, 1'b1);
    add_instr(6'd13, 5'd12, 5'd0, F_CSR);
    hold_stalls(1'b1, 1'b1);
    predict();
    limit = n_rows * 4 + RESET_CYCLES + 20;

    rst_n <= 1'b0;
    drive_row('0);
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    drive_row(rows[0]);
    for (int i = 0; i < n_rows; i++) begin
      cur_row = i;
      @(negedge clk);
      check_bit("stall", stall, rows[i].exp_stall);
      if (rows[i].exp_stall) begin
        repeat (2) begin
          @(posedge clk);
          @(negedge clk);
          check_bit("stall", stall, 1'b1);
          check_robid("robid", robid, prev_id);
        end
        @(posedge clk);
        exers_stall <= 1'b0;
        lsq_stall <= 1'b0;
        @(negedge clk);
        check_bit("stall", stall, 1'b0);
      end
      @(posedge clk);
      if (i + 1 < n_rows) drive_row(rows[i+1]);
      else drive_row('0);
      @(negedge clk);
      check_target("target", seen_target(), rows[i].exp_tgt);
      if (rows[i].exp_tgt != TGT_NONE) begin
        check_robid("robid", robid, rows[i].id);
        check_op("op", op, rows[i].id[`OP_W-1:0]);
        check_rd("rd", rd, rows[i].rd);
        check_word("imm", imm, rows[i].imm);
        check_operand("op1", op1ready, op1, rows[i].exp_r1, rows[i].exp_op1);
        check_operand("op2", op2ready, op2, rows[i].exp_r2, rows[i].exp_op2);
        prev_id = rows[i].id;
      end
    end
    @(posedge clk);
    $display("errors: %0d in %0d checks", errors, checks);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== rename_unit_top.sv ====
// wiring only; queue stalls must stay low while rst_n is low
`timescale 1ns/1ps
`include "rename_config.svh"

module rename_unit_top import rename_types_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   decode_valid,
  input  logic [`XLEN-1:2]       decode_addr,
  input  logic [`OP_W-1:0]       decode_rsop,
  input  robid_t                 decode_robid,
  input  logic [`RD_W-1:0]       decode_rd,
  input  logic [`ARCH_REG_W-1:0] decode_rs1,
  input  logic [`ARCH_REG_W-1:0] decode_rs2,
  input  logic [`XLEN-1:0]       decode_imm,
  input  logic                   decode_uses_rs1,
  input  logic                   decode_uses_rs2,
  input  logic                   decode_uses_imm,
  input  logic                   decode_uses_memory,
  input  logic                   decode_uses_pc,
  input  logic                   decode_csr_access,
  output logic                   stall,
  input  logic                   wb_valid,
  input  robid_t                 wb_robid,
  input  logic [`XLEN-1:0]       wb_value,
  input  logic                   exers_stall,
  input  logic                   lsq_stall,
  input  logic                   flush,
  output logic                   exers_write,
  output logic                   lsq_write,
  output logic                   csr_write,
  output logic [`OP_W-1:0]       op,
  output robid_t                 robid,
  output logic [`RD_W-1:0]       rd,
  output logic                   op1ready,
  output logic [`XLEN-1:0]       op1,
  output logic                   op2ready,
  output logic [`XLEN-1:0]       op2,
  output logic [`XLEN-1:0]       imm
);

  logic                   rat_write;
  logic [`RD_W-1:0]       rat_rd;
  robid_t                 rat_robid;
  logic [`ARCH_REG_W-1:0] rat_rs1;
  logic [`ARCH_REG_W-1:0] rat_rs2;
  logic                   rs1_ready;
  logic                   rs2_ready;
  tag_or_value_u          rs1_tagval;
  tag_or_value_u          rs2_tagval;

  rename rename_i (
    .clk, .rst_n,
    .decode_valid, .decode_addr, .decode_rsop, .decode_robid, .decode_rd,
    .decode_rs1, .decode_rs2, .decode_imm,
    .decode_uses_rs1, .decode_uses_rs2, .decode_uses_imm,
    .decode_uses_memory, .decode_uses_pc, .decode_csr_access,
    .rs1_ready, .rs1_tagval, .rs2_ready, .rs2_tagval,
    .exers_stall, .lsq_stall, .flush, .stall,
    .rat_write, .rat_rd, .rat_robid, .rat_rs1, .rat_rs2,
    .exers_write, .lsq_write, .csr_write,
    .op, .robid, .rd, .op1ready, .op1, .op2ready, .op2, .imm
  );

  // stall freezes the registered reads with the stage
  rat rat_i (
    .clk, .rst_n,
    .rat_write, .rat_rd, .rat_robid, .rat_rs1, .rat_rs2,
    .hold (stall),
    .wb_valid, .wb_robid, .wb_value, .flush,
    .rs1_ready, .rs1_tagval, .rs2_ready, .rs2_tagval
  );

endmodule

// ==== rename.sv ====
// stall follows the decode slot's class even with decode_valid low; queues ignore writes while stalled
`timescale 1ns/1ps
`include "rename_config.svh"

module rename import rename_types_pkg::*, dispatch_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   decode_valid,
  input  logic [`XLEN-1:2]       decode_addr,
  input  logic [`OP_W-1:0]       decode_rsop,
  input  robid_t                 decode_robid,
  input  logic [`RD_W-1:0]       decode_rd,
  input  logic [`ARCH_REG_W-1:0] decode_rs1,
  input  logic [`ARCH_REG_W-1:0] decode_rs2,
  input  logic [`XLEN-1:0]       decode_imm,
  input  logic                   decode_uses_rs1,
  input  logic                   decode_uses_rs2,
  input  logic                   decode_uses_imm,
  input  logic                   decode_uses_memory,
  input  logic                   decode_uses_pc,
  input  logic                   decode_csr_access,
  input  logic                   rs1_ready,
  input  tag_or_value_u          rs1_tagval,
  input  logic                   rs2_ready,
  input  tag_or_value_u          rs2_tagval,
  input  logic                   exers_stall,
  input  logic                   lsq_stall,
  input  logic                   flush,
  output logic                   stall,
  output logic                   rat_write,
  output logic [`RD_W-1:0]       rat_rd,
  output robid_t                 rat_robid,
  output logic [`ARCH_REG_W-1:0] rat_rs1,
  output logic [`ARCH_REG_W-1:0] rat_rs2,
  output logic                   exers_write,
  output logic                   lsq_write,
  output logic                   csr_write,
  output logic [`OP_W-1:0]       op,
  output robid_t                 robid,
  output logic [`RD_W-1:0]       rd,
  output logic                   op1ready,
  output logic [`XLEN-1:0]       op1,
  output logic                   op2ready,
  output logic [`XLEN-1:0]       op2,
  output logic [`XLEN-1:0]       imm
);

  dispatch_target_e in_class;
  dispatch_target_e tgt_q;
  operand_form_e    form_q;
  logic [`XLEN-1:0] addr_q;
  logic [`XLEN-1:0] imm_q;
  logic [`OP_W-1:0] op_q;
  robid_t           robid_q;
  logic [`RD_W-1:0] rd_q;

  assign in_class = route(decode_uses_memory, decode_csr_access);
  assign stall    = ((in_class == TGT_EXERS) && exers_stall) ||
                    ((in_class == TGT_LSQ) && lsq_stall);

  // RAT side straight from decode
  assign rat_write = decode_valid && !stall && !decode_rd[`RD_W-1] &&
                     (decode_rd[`ARCH_REG_W-1:0] != '0);
  assign rat_rd    = decode_rd;
  assign rat_robid = decode_robid;
  assign rat_rs1   = decode_rs1;
  assign rat_rs2   = decode_rs2;

  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      tgt_q <= TGT_NONE;
    end else if (!stall) begin
      tgt_q <= decode_valid ? in_class : TGT_NONE;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      addr_q  <= {decode_addr, 2'b00};
      imm_q   <= decode_imm;
      op_q    <= decode_rsop;
      robid_q <= decode_robid;
      rd_q    <= decode_rd;
      form_q  <= operand_form(decode_uses_rs1, decode_uses_pc,
                              decode_uses_rs2, decode_uses_imm);
    end
  end

  assign exers_write = (tgt_q == TGT_EXERS);
  assign lsq_write   = (tgt_q == TGT_LSQ);
  assign csr_write   = (tgt_q == TGT_CSR);
  assign op          = op_q;
  assign robid       = robid_q;
  assign rd          = rd_q;
  assign imm         = imm_q;

  // RAT words go out raw, a value or a tag word per ready
  always_comb begin
    op1ready = 1'b1;
    op1      = '0;
    op2ready = 1'b1;
    op2      = '0;
    case (form_q)
      FORM_LUI: begin
        op1 = imm_q;
      end
      FORM_PC: begin
        op1 = addr_q;
        op2 = imm_q;
      end
      FORM_REG_IMM: begin
        op1ready = rs1_ready;
        op1      = rs1_tagval;
        op2      = imm_q;
      end
      FORM_REG_REG: begin
        op1ready = rs1_ready;
        op1      = rs1_tagval;
        op2ready = rs2_ready;
        op2      = rs2_tagval;
      end
      default: begin
        op1 = '0;
      end
    endcase
  end

  one_queue: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({exers_write, lsq_write, csr_write}));

  // decode never sends rs1 together with pc
  legal_op1: assert property (@(posedge clk) disable iff (!rst_n)
    decode_valid |-> !(decode_uses_rs1 && decode_uses_pc));

  // queues are held in reset too, so their stalls stay low
  quiet_in_reset: assert property (@(posedge clk) !rst_n |-> !stall);

endmodule

// ==== rat.sv ====
// no checkpoint recovery: flush only marks entries ready, values stay at the last writeback
`timescale 1ns/1ps
`include "rename_config.svh"

module rat import rename_types_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   rat_write,
  input  logic [`RD_W-1:0]       rat_rd,
  input  robid_t                 rat_robid,
  input  logic [`ARCH_REG_W-1:0] rat_rs1,
  input  logic [`ARCH_REG_W-1:0] rat_rs2,
  input  logic                   hold,
  input  logic                   wb_valid,
  input  robid_t                 wb_robid,
  input  logic [`XLEN-1:0]       wb_value,
  input  logic                   flush,
  output logic                   rs1_ready,
  output tag_or_value_u          rs1_tagval,
  output logic                   rs2_ready,
  output tag_or_value_u          rs2_tagval
);

  logic [`RAT_DEPTH-1:0]  ready;
  tag_or_value_u          entry [`RAT_DEPTH];
  logic [`RAT_DEPTH-1:0]  wb_hit;
  logic [`ARCH_REG_W-1:0] wr_idx;
  logic                   wr_en;
  logic                   rs1_sel_ready;
  logic                   rs2_sel_ready;
  tag_or_value_u          rs1_sel;
  tag_or_value_u          rs2_sel;

  // pending word completed by this cycle's writeback
  function automatic logic wb_match(logic rdy, tag_or_value_u word);
    return wb_valid && !rdy && (word.tag.robid == wb_robid);
  endfunction

  assign wr_idx = rat_rd[`ARCH_REG_W-1:0];
  assign wr_en  = rat_write && !rat_rd[`RD_W-1] && (wr_idx != '0) && !flush;

  always_comb begin
    for (int i = 0; i < `RAT_DEPTH; i++) begin
      wb_hit[i] = wb_match(ready[i], entry[i]);
    end
  end

  // x0 is never touched after reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ready <= '1;
      for (int i = 0; i < `RAT_DEPTH; i++) begin
        entry[i] <= '0;
      end
    end else begin
      for (int i = 1; i < `RAT_DEPTH; i++) begin
        if (wr_en && (wr_idx == i)) begin
          ready[i] <= 1'b0;
          entry[i] <= make_tag(rat_robid);
        end else begin
          if (wb_hit[i]) begin
            ready[i] <= 1'b1;
            entry[i] <= make_value(wb_value);
          end
          if (flush) begin
            ready[i] <= 1'b1;
          end
        end
      end
    end
  end

  // held operand or fresh read, either one snoops the writeback
  assign rs1_sel_ready = hold ? rs1_ready : ready[rat_rs1];
  assign rs1_sel       = hold ? rs1_tagval : entry[rat_rs1];
  assign rs2_sel_ready = hold ? rs2_ready : ready[rat_rs2];
  assign rs2_sel       = hold ? rs2_tagval : entry[rat_rs2];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rs1_ready <= 1'b1;
      rs2_ready <= 1'b1;
    end else begin
      rs1_ready <= rs1_sel_ready || wb_match(rs1_sel_ready, rs1_sel);
      rs2_ready <= rs2_sel_ready || wb_match(rs2_sel_ready, rs2_sel);
    end
  end

  always_ff @(posedge clk) begin
    rs1_tagval <= wb_match(rs1_sel_ready, rs1_sel) ? make_value(wb_value) : rs1_sel;
    rs2_tagval <= wb_match(rs2_sel_ready, rs2_sel) ? make_value(wb_value) : rs2_sel;
  end

  // rename must not retag while the stage is frozen
  no_write_on_hold: assert property (@(posedge clk) disable iff (!rst_n)
    hold |-> !rat_write);

endmodule

// ==== dispatch_pkg.sv ====
// memory wins over csr_access when both are set; flag sets outside the four forms give FORM_UNDEF
package dispatch_pkg;

  typedef enum logic [1:0] {
    TGT_NONE  = 2'd0,
    TGT_EXERS = 2'd1,
    TGT_LSQ   = 2'd2,
    TGT_CSR   = 2'd3
  } dispatch_target_e;

  typedef enum logic [2:0] {
    FORM_LUI     = 3'd0,
    FORM_PC      = 3'd1,
    FORM_REG_IMM = 3'd2,
    FORM_REG_REG = 3'd3,
    FORM_UNDEF   = 3'd4
  } operand_form_e;

  // queue for an instruction of this class, valid or not
  function automatic dispatch_target_e route(logic uses_memory, logic csr_access);
    if (uses_memory) return TGT_LSQ;
    if (csr_access) return TGT_CSR;
    return TGT_EXERS;
  endfunction

  // stores use rs2 and imm, rs2 takes op2
  function automatic operand_form_e operand_form(logic uses_rs1, logic uses_pc,
                                                 logic uses_rs2, logic uses_imm);
    if (!uses_rs1) return uses_pc ? FORM_PC : FORM_LUI;
    if (uses_pc) return FORM_UNDEF;
    if (uses_rs2) return FORM_REG_REG;
    return uses_imm ? FORM_REG_IMM : FORM_UNDEF;
  endfunction

endpackage

// ==== rename_types_pkg.sv ====
// tag words keep every bit above the robid at zero; needs rename_config.svh on the include path
`include "rename_config.svh"

package rename_types_pkg;

  typedef logic [`ROBID_W-1:0] robid_t;

  // one RAT word, read as a value when its ready bit is set and as a tag otherwise
  typedef union packed {
    logic [`XLEN-1:0] value;
    struct packed {
      logic [`XLEN-`ROBID_W-1:0] zero;
      robid_t                    robid;
    } tag;
  } tag_or_value_u;

  // pending entry word for a producer robid
  function automatic tag_or_value_u make_tag(robid_t id);
    tag_or_value_u w;
    w.tag.zero  = '0;
    w.tag.robid = id;
    return w;
  endfunction

  // completed entry word
  function automatic tag_or_value_u make_value(logic [`XLEN-1:0] v);
    tag_or_value_u w;
    w.value = v;
    return w;
  endfunction

endpackage

// ==== rename_config.svh ====
// RAT_DEPTH must equal 2**ARCH_REG_W and ROBID_W must stay below XLEN
`ifndef RENAME_CONFIG_SVH
`define RENAME_CONFIG_SVH

// data path
`define XLEN 32

// reorder buffer id
`define ROBID_W 8

// register fields, rd msb set means no write
`define ARCH_REG_W 5
`define RD_W 6

// reservation station opcode
`define OP_W 5

`define RAT_DEPTH 32

`endif
